/* list.f */
+incdir+src
src/isaPkg.sv
src/ctrlPkg.sv
src/insDecode.sv
src/stateSequencer.sv
src/controlWordTable.sv
src/controlUnit.sv
sim/clkGen.sv
sim/tbControlUnit.sv

/* run.sh */
#!/usr/bin/env bash
# Build the control unit testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module tbControlUnit -f list.f -o simControlUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simControlUnit > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$logFile"; then
	exit 0
else
	echo "Pass message not found in $logFile"
	exit 1
fi

/* sim/tbControlUnit.sv */
`timescale 1ns/10ps
`include "ctrlUnit_consts.svh"

module tbControlUnit;

	localparam int NUM_INSTR = 300;
	localparam int MAX_LOW = 16;
	// Eight states plus a fetch wait and one wait inside the instruction
	localparam int MAX_PATH = 8 + 2 * (MAX_LOW + 1);
	localparam int ENDOP_HOLD = 20;
	localparam int CYCLE_LIMIT = NUM_INSTR * MAX_PATH + ENDOP_HOLD + `TIMEOUT_SLACK;
	localparam isaPkg::stateT OPCODES [27] = '{
		isaPkg::RSTALL, isaPkg::RSTAC, isaPkg::RSTADDR, isaPkg::RSTGSP, isaPkg::RSTMC,
		isaPkg::RSTCP, isaPkg::RSTRP, isaPkg::INCGSP, isaPkg::INCAC, isaPkg::INCCP,
		isaPkg::INCRP, isaPkg::INCMC, isaPkg::INCSTP, isaPkg::LDADDR_1, isaPkg::LDAC_1,
		isaPkg::LDMULR_1, isaPkg::LDRP_1, isaPkg::LDCP_1, isaPkg::STSP_1, isaPkg::ADD,
		isaPkg::MUL1, isaPkg::MUL2, isaPkg::DIV, isaPkg::MOD, isaPkg::JMPZ1,
		isaPkg::JMPZ2, isaPkg::JMP_1
	};

	logic                    clk;
	logic                    rstN;
	logic [`STATE_WIDTH-1:0] ins;
	logic                    iacq;
	logic                    acq;
	logic                    z1;
	logic                    z2;
	isaPkg::stateT           state;
	ctrlPkg::aluOpT          aluOp;
	ctrlPkg::busSelT         busSelect;
	ctrlPkg::pCtrlT          pCtrl;
	ctrlPkg::memCtrlT        memCtrl;
	logic [`REG_COUNT-1:0]   rstEn;
	logic [`REG_COUNT-1:0]   incEn;
	logic [`REG_COUNT-1:0]   wrtEn;

	// Model state and the word expected on the outputs
	isaPkg::stateT           modelState;
	isaPkg::stateT           expState;
	ctrlPkg::aluOpT          expAluOp;
	ctrlPkg::busSelT         expBusSelect;
	ctrlPkg::pCtrlT          expPCtrl;
	ctrlPkg::memCtrlT        expMemCtrl;
	logic [`REG_COUNT-1:0]   expRstEn;
	logic [`REG_COUNT-1:0]   expIncEn;
	logic [`REG_COUNT-1:0]   expWrtEn;

	integer                  seed;
	int                      cycleCount;
	int                      instrCount;
	int                      endopCycles;
	int                      iacqLow;
	int                      acqLow;

	clkGen u_clkGen (
		.clk  (clk),
		.rstN (rstN)
	);

	controlUnit u_controlUnit (
		.clk       (clk),
		.rstN      (rstN),
		.ins       (ins),
		.iacq      (iacq),
		.acq       (acq),
		.z1        (z1),
		.z2        (z2),
		.state     (state),
		.aluOp     (aluOp),
		.busSelect (busSelect),
		.pCtrl     (pCtrl),
		.memCtrl   (memCtrl),
		.rstEn     (rstEn),
		.incEn     (incEn),
		.wrtEn     (wrtEn)
	);

	function automatic logic [`REG_COUNT-1:0] oneHot(input ctrlPkg::regIdxT idx);
		return `REG_COUNT'(1) << idx;
	endfunction

	// Kept opcodes and ENDOP enter their own state, anything else refetches
	function automatic isaPkg::stateT entryFor(input logic [`STATE_WIDTH-1:0] opcode);
		isaPkg::stateT entry;
		entry = isaPkg::FETCH_1;
		for (int i = 0; i < 27; i++) begin
			if (opcode == OPCODES[i]) begin
				entry = OPCODES[i];
			end
		end
		if (opcode == isaPkg::ENDOP) begin
			entry = isaPkg::ENDOP;
		end
		return entry;
	endfunction

	function automatic isaPkg::stateT stepModel(input isaPkg::stateT s,
			input logic [`STATE_WIDTH-1:0] insV, input logic iacqV, input logic acqV,
			input logic z1V, input logic z2V);
		case (s)
			isaPkg::FETCH_1:  return iacqV ? isaPkg::FETCH_2 : s;
			isaPkg::FETCH_2:  return isaPkg::FETCH_3;
			isaPkg::FETCH_3:  return entryFor(insV);
			isaPkg::LDADDR_1: return acqV ? isaPkg::LDADDR_2 : s;
			isaPkg::LDAC_1:   return acqV ? isaPkg::LDAC_2 : s;
			isaPkg::LDMULR_1: return acqV ? isaPkg::LDMULR_2 : s;
			isaPkg::LDRP_1:   return acqV ? isaPkg::LDRP_2 : s;
			isaPkg::LDCP_1:   return acqV ? isaPkg::LDCP_2 : s;
			isaPkg::STSP_1:   return acqV ? isaPkg::FETCH_1 : s;
			isaPkg::JMPZ1:    return z1V ? isaPkg::JMPZ1Y_1 : isaPkg::JMPZ1N_1;
			isaPkg::JMPZ1Y_1: return iacqV ? isaPkg::JMPZ1Y_2 : s;
			isaPkg::JMPZ1Y_2: return isaPkg::JMPZ1Y_3;
			isaPkg::JMPZ1N_1: return isaPkg::JMPZ1N_2;
			isaPkg::JMPZ1N_2: return iacqV ? isaPkg::JMPZ1N_3 : s;
			isaPkg::JMPZ2:    return z2V ? isaPkg::JMPZ2N_1 : isaPkg::JMPZ2Y_1;
			isaPkg::JMPZ2Y_1: return iacqV ? isaPkg::JMPZ2Y_2 : s;
			isaPkg::JMPZ2Y_2: return isaPkg::JMPZ2Y_3;
			isaPkg::JMPZ2N_1: return isaPkg::JMPZ2N_2;
			isaPkg::JMPZ2N_2: return iacqV ? isaPkg::FETCH_1 : s;
			isaPkg::JMP_1:    return iacqV ? isaPkg::JMP_2 : s;
			isaPkg::JMP_2:    return isaPkg::JMP_3;
			isaPkg::JMP_3:    return isaPkg::JMP_4;
			isaPkg::ENDOP:    return s;
			// Single-cycle states and the last step of each chain
			default:          return isaPkg::FETCH_1;
		endcase
	endfunction

	task automatic predictWord(input isaPkg::stateT s);
		expState     = s;
		expAluOp     = ctrlPkg::ALU_NONE;
		expBusSelect = ctrlPkg::BS_AC;
		expPCtrl     = ctrlPkg::P_GSP;
		expMemCtrl   = ctrlPkg::MEM_IDLE;
		expRstEn     = '0;
		expIncEn     = '0;
		expWrtEn     = '0;
		if (s inside {isaPkg::JMPZ1, isaPkg::JMPZ2, isaPkg::JMP_1, isaPkg::JMP_2,
				isaPkg::JMP_3, isaPkg::JMP_4, isaPkg::JMPZ1Y_1, isaPkg::JMPZ1Y_2,
				isaPkg::JMPZ1Y_3, isaPkg::JMPZ1N_1, isaPkg::JMPZ1N_2, isaPkg::JMPZ1N_3,
				isaPkg::JMPZ2Y_1, isaPkg::JMPZ2Y_2, isaPkg::JMPZ2Y_3, isaPkg::JMPZ2N_1,
				isaPkg::JMPZ2N_2}) begin
			expMemCtrl = ctrlPkg::MEM_IREAD;
		end
		case (s)
			isaPkg::FETCH_1: expMemCtrl = ctrlPkg::MEM_IREAD;
			isaPkg::FETCH_2: begin
				expIncEn = oneHot(ctrlPkg::R_PC);
				expWrtEn = oneHot(ctrlPkg::R_IR);
			end
			isaPkg::RSTALL: begin
				for (int i = ctrlPkg::R_GSP; i <= ctrlPkg::R_AC; i++) begin
					expRstEn[i] = 1'b1;
				end
			end
			isaPkg::RSTAC:   expRstEn = oneHot(ctrlPkg::R_AC);
			isaPkg::RSTADDR: expRstEn = oneHot(ctrlPkg::R_ADDR);
			isaPkg::RSTGSP:  expRstEn = oneHot(ctrlPkg::R_GSP);
			isaPkg::RSTMC:   expRstEn = oneHot(ctrlPkg::R_MC);
			isaPkg::RSTCP:   expRstEn = oneHot(ctrlPkg::R_CP);
			isaPkg::RSTRP:   expRstEn = oneHot(ctrlPkg::R_RP);
			isaPkg::INCGSP:  expIncEn = oneHot(ctrlPkg::R_GSP);
			isaPkg::INCAC:   expIncEn = oneHot(ctrlPkg::R_AC);
			isaPkg::INCCP:   expIncEn = oneHot(ctrlPkg::R_CP);
			isaPkg::INCRP:   expIncEn = oneHot(ctrlPkg::R_RP);
			isaPkg::INCMC:   expIncEn = oneHot(ctrlPkg::R_MC);
			isaPkg::INCSTP:  expIncEn = oneHot(ctrlPkg::R_STP);
			isaPkg::LDADDR_1, isaPkg::LDAC_1, isaPkg::LDMULR_1: expMemCtrl = ctrlPkg::MEM_READ;
			isaPkg::LDRP_1: begin
				expMemCtrl = ctrlPkg::MEM_READ;
				expPCtrl   = ctrlPkg::P_RP;
			end
			isaPkg::LDCP_1: begin
				expMemCtrl = ctrlPkg::MEM_READ;
				expPCtrl   = ctrlPkg::P_CP;
			end
			isaPkg::LDADDR_2: begin
				expBusSelect = ctrlPkg::BS_MEMOUT;
				expWrtEn     = oneHot(ctrlPkg::R_ADDR);
			end
			isaPkg::LDAC_2: begin
				expBusSelect = ctrlPkg::BS_MEMOUT;
				expMemCtrl   = ctrlPkg::MEM_READ;
				expWrtEn     = oneHot(ctrlPkg::R_AC);
			end
			isaPkg::LDMULR_2, isaPkg::LDRP_2: begin
				expBusSelect = ctrlPkg::BS_MEMOUT;
				expWrtEn     = oneHot(ctrlPkg::R_MULR);
			end
			isaPkg::LDCP_2: begin
				expBusSelect = ctrlPkg::BS_MEMOUT;
				expWrtEn     = oneHot(ctrlPkg::R_AC);
			end
			isaPkg::STSP_1: begin
				expPCtrl   = ctrlPkg::P_STP;
				expMemCtrl = ctrlPkg::MEM_WRITE;
			end
			isaPkg::ADD: begin
				expAluOp     = ctrlPkg::ALU_ADD;
				expBusSelect = ctrlPkg::BS_ADDR;
			end
			isaPkg::MUL1: begin
				expAluOp     = ctrlPkg::ALU_MUL;
				expBusSelect = ctrlPkg::BS_MULR;
			end
			isaPkg::MUL2: begin
				expAluOp     = ctrlPkg::ALU_MUL;
				expBusSelect = ctrlPkg::BS_MV;
			end
			isaPkg::DIV: begin
				expAluOp     = ctrlPkg::ALU_DIV;
				expBusSelect = ctrlPkg::BS_WV;
			end
			isaPkg::MOD: begin
				expAluOp     = ctrlPkg::ALU_MOD;
				expBusSelect = ctrlPkg::BS_WV;
			end
			isaPkg::JMPZ1Y_1, isaPkg::JMPZ2Y_1: expWrtEn = oneHot(ctrlPkg::R_IR);
			isaPkg::JMPZ1Y_2, isaPkg::JMPZ2Y_2, isaPkg::JMP_3: expWrtEn = oneHot(ctrlPkg::R_PC);
			isaPkg::JMPZ1N_1, isaPkg::JMPZ2N_1: begin
				expIncEn = oneHot(ctrlPkg::R_PC);
				expWrtEn = oneHot(ctrlPkg::R_IR);
			end
			default: ;
		endcase
	endtask

	task automatic stopOnFailure();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkOutputs();
		checkValue("state", expState, state);
		checkValue("aluOp", expAluOp, aluOp);
		checkValue("busSelect", expBusSelect, busSelect);
		checkValue("pCtrl", expPCtrl, pCtrl);
		checkValue("memCtrl", expMemCtrl, memCtrl);
		checkValue("rstEn", expRstEn, rstEn);
		checkValue("incEn", expIncEn, incEn);
		checkValue("wrtEn", expWrtEn, wrtEn);
	endtask

	task automatic driveInputs();
		logic [`STATE_WIDTH-1:0] nextIns;
		logic                    nextIacq;
		logic                    nextAcq;
		nextIns = `STATE_WIDTH'($random(seed));
		// Byte driven now is decoded at the next edge
		if (modelState == isaPkg::FETCH_3) begin
			instrCount++;
			if (instrCount >= NUM_INSTR) begin
				nextIns = isaPkg::ENDOP;
			end else if (($random(seed) & 7) == 0) begin
				if (entryFor(nextIns) != isaPkg::FETCH_1) begin
					nextIns = 8'h00;
				end
			end else begin
				nextIns = OPCODES[$unsigned($random(seed)) % 27];
			end
		end
		nextIacq = 1'($random(seed));
		nextAcq  = 1'($random(seed));
		// Bound every wait so the run length is known
		if (iacqLow >= MAX_LOW) begin
			nextIacq = 1'b1;
		end
		if (acqLow >= MAX_LOW) begin
			nextAcq = 1'b1;
		end
		iacqLow = nextIacq ? 0 : iacqLow + 1;
		acqLow  = nextAcq ? 0 : acqLow + 1;
		ins  <= nextIns;
		iacq <= nextIacq;
		acq  <= nextAcq;
		z1   <= 1'($random(seed));
		z2   <= 1'($random(seed));
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not reach ENDOP within %0d cycles", CYCLE_LIMIT);
			stopOnFailure();
		end
	end

	initial begin
		seed        = 81379;
		cycleCount  = 0;
		instrCount  = 0;
		endopCycles = 0;
		iacqLow     = 0;
		acqLow      = 0;
		ins         = '0;
		iacq        = 1'b0;
		acq         = 1'b0;
		z1          = 1'b0;
		z2          = 1'b0;
		modelState  = isaPkg::FETCH_1;
		predictWord(isaPkg::FETCH_1);
		// Right after reset FETCH_1 is shown with memory still idle
		expMemCtrl  = ctrlPkg::MEM_IDLE;
		@(posedge rstN);
		while (endopCycles < ENDOP_HOLD) begin
			@(posedge clk);
			checkOutputs();
			if (expState == isaPkg::ENDOP) begin
				endopCycles++;
			end
			predictWord(modelState);
			modelState = stepModel(modelState, ins, iacq, acq, z1, z2);
			driveInputs();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* sim/clkGen.sv */
`timescale 1ns/10ps

module clkGen (
	output logic clk,
	output logic rstN
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Low across the first two rising edges
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

/* src/controlUnit.sv */
`timescale 1ns/10ps
`include "ctrlUnit_consts.svh"

module controlUnit (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic [`STATE_WIDTH-1:0] ins,
	input  logic                    iacq,
	input  logic                    acq,
	input  logic                    z1,
	input  logic                    z2,
	output isaPkg::stateT           state,
	output ctrlPkg::aluOpT          aluOp,
	output ctrlPkg::busSelT         busSelect,
	output ctrlPkg::pCtrlT          pCtrl,
	output ctrlPkg::memCtrlT        memCtrl,
	output logic [`REG_COUNT-1:0]   rstEn,
	output logic [`REG_COUNT-1:0]   incEn,
	output logic [`REG_COUNT-1:0]   wrtEn
);

	isaPkg::stateT entryState;
	isaPkg::stateT curState;

	insDecode u_insDecode (
		.ins        (ins),
		.entryState (entryState)
	);

	stateSequencer u_stateSequencer (
		.clk        (clk),
		.rstN       (rstN),
		.iacq       (iacq),
		.acq        (acq),
		.z1         (z1),
		.z2         (z2),
		.entryState (entryState),
		.curState   (curState)
	);

	// Outputs trail curState by one cycle
	controlWordTable u_controlWordTable (
		.clk       (clk),
		.rstN      (rstN),
		.curState  (curState),
		.state     (state),
		.aluOp     (aluOp),
		.busSelect (busSelect),
		.pCtrl     (pCtrl),
		.memCtrl   (memCtrl),
		.rstEn     (rstEn),
		.incEn     (incEn),
		.wrtEn     (wrtEn)
	);

endmodule

/* src/controlWordTable.sv */
`timescale 1ns/10ps
`include "ctrlUnit_consts.svh"

module controlWordTable (
	input  logic                  clk,
	input  logic                  rstN,
	input  isaPkg::stateT         curState,
	output isaPkg::stateT         state,
	output ctrlPkg::aluOpT        aluOp,
	output ctrlPkg::busSelT       busSelect,
	output ctrlPkg::pCtrlT        pCtrl,
	output ctrlPkg::memCtrlT      memCtrl,
	output logic [`REG_COUNT-1:0] rstEn,
	output logic [`REG_COUNT-1:0] incEn,
	output logic [`REG_COUNT-1:0] wrtEn
);

	ctrlPkg::aluOpT        nextAluOp;
	ctrlPkg::busSelT       nextBusSelect;
	ctrlPkg::pCtrlT        nextPCtrl;
	ctrlPkg::memCtrlT      nextMemCtrl;
	logic [`REG_COUNT-1:0] nextRstEn;
	logic [`REG_COUNT-1:0] nextIncEn;
	logic [`REG_COUNT-1:0] nextWrtEn;

	function automatic logic [`REG_COUNT-1:0] regBit(input ctrlPkg::regIdxT idx);
		logic [`REG_COUNT-1:0] vec;
		vec = '0;
		vec[idx] = 1'b1;
		return vec;
	endfunction

	always_comb begin
		// Idle word unless the state says otherwise
		nextAluOp     = ctrlPkg::ALU_NONE;
		nextBusSelect = ctrlPkg::BS_AC;
		nextPCtrl     = ctrlPkg::P_GSP;
		nextMemCtrl   = ctrlPkg::MEM_IDLE;
		nextRstEn     = '0;
		nextIncEn     = '0;
		nextWrtEn     = '0;
		case (curState)
			isaPkg::FETCH_1: nextMemCtrl = ctrlPkg::MEM_IREAD;
			isaPkg::FETCH_2: begin
				nextIncEn = regBit(ctrlPkg::R_PC);
				nextWrtEn = regBit(ctrlPkg::R_IR);
			end

			// Everything above PC and IR
			isaPkg::RSTALL:  nextRstEn = {`REG_COUNT{1'b1}} << ctrlPkg::R_GSP;
			isaPkg::RSTAC:   nextRstEn = regBit(ctrlPkg::R_AC);
			isaPkg::RSTADDR: nextRstEn = regBit(ctrlPkg::R_ADDR);
			isaPkg::RSTGSP:  nextRstEn = regBit(ctrlPkg::R_GSP);
			isaPkg::RSTMC:   nextRstEn = regBit(ctrlPkg::R_MC);
			isaPkg::RSTCP:   nextRstEn = regBit(ctrlPkg::R_CP);
			isaPkg::RSTRP:   nextRstEn = regBit(ctrlPkg::R_RP);

			isaPkg::INCGSP:  nextIncEn = regBit(ctrlPkg::R_GSP);
			isaPkg::INCAC:   nextIncEn = regBit(ctrlPkg::R_AC);
			isaPkg::INCCP:   nextIncEn = regBit(ctrlPkg::R_CP);
			isaPkg::INCRP:   nextIncEn = regBit(ctrlPkg::R_RP);
			isaPkg::INCMC:   nextIncEn = regBit(ctrlPkg::R_MC);
			isaPkg::INCSTP:  nextIncEn = regBit(ctrlPkg::R_STP);

			// Memory read request, pointer picked per load
			isaPkg::LDADDR_1,
			isaPkg::LDAC_1,
			isaPkg::LDMULR_1: nextMemCtrl = ctrlPkg::MEM_READ;
			isaPkg::LDRP_1: begin
				nextMemCtrl = ctrlPkg::MEM_READ;
				nextPCtrl   = ctrlPkg::P_RP;
			end
			isaPkg::LDCP_1: begin
				nextMemCtrl = ctrlPkg::MEM_READ;
				nextPCtrl   = ctrlPkg::P_CP;
			end

			// Memory data onto the bus
			isaPkg::LDADDR_2: begin
				nextBusSelect = ctrlPkg::BS_MEMOUT;
				nextWrtEn     = regBit(ctrlPkg::R_ADDR);
			end
			isaPkg::LDAC_2: begin
				nextBusSelect = ctrlPkg::BS_MEMOUT;
				nextMemCtrl   = ctrlPkg::MEM_READ;
				nextWrtEn     = regBit(ctrlPkg::R_AC);
			end
			isaPkg::LDMULR_2,
			isaPkg::LDRP_2: begin
				nextBusSelect = ctrlPkg::BS_MEMOUT;
				nextWrtEn     = regBit(ctrlPkg::R_MULR);
			end
			isaPkg::LDCP_2: begin
				nextBusSelect = ctrlPkg::BS_MEMOUT;
				nextWrtEn     = regBit(ctrlPkg::R_AC);
			end

			isaPkg::STSP_1: begin
				nextPCtrl   = ctrlPkg::P_STP;
				nextMemCtrl = ctrlPkg::MEM_WRITE;
			end

			isaPkg::ADD: begin
				nextAluOp     = ctrlPkg::ALU_ADD;
				nextBusSelect = ctrlPkg::BS_ADDR;
			end
			isaPkg::MUL1: begin
				nextAluOp     = ctrlPkg::ALU_MUL;
				nextBusSelect = ctrlPkg::BS_MULR;
			end
			isaPkg::MUL2: begin
				nextAluOp     = ctrlPkg::ALU_MUL;
				nextBusSelect = ctrlPkg::BS_MV;
			end
			isaPkg::DIV: begin
				nextAluOp     = ctrlPkg::ALU_DIV;
				nextBusSelect = ctrlPkg::BS_WV;
			end
			isaPkg::MOD: begin
				nextAluOp     = ctrlPkg::ALU_MOD;
				nextBusSelect = ctrlPkg::BS_WV;
			end

			// Jump chains keep the instruction memory reading
			isaPkg::JMPZ1Y_1,
			isaPkg::JMPZ2Y_1: begin
				nextMemCtrl = ctrlPkg::MEM_IREAD;
				nextWrtEn   = regBit(ctrlPkg::R_IR);
			end
			isaPkg::JMPZ1Y_2,
			isaPkg::JMPZ2Y_2,
			isaPkg::JMP_3: begin
				nextMemCtrl = ctrlPkg::MEM_IREAD;
				nextWrtEn   = regBit(ctrlPkg::R_PC);
			end
			// Not taken, skip the target byte
			isaPkg::JMPZ1N_1,
			isaPkg::JMPZ2N_1: begin
				nextMemCtrl = ctrlPkg::MEM_IREAD;
				nextIncEn   = regBit(ctrlPkg::R_PC);
				nextWrtEn   = regBit(ctrlPkg::R_IR);
			end
			isaPkg::JMPZ1,
			isaPkg::JMPZ2,
			isaPkg::JMPZ1Y_3,
			isaPkg::JMPZ2Y_3,
			isaPkg::JMPZ1N_2,
			isaPkg::JMPZ1N_3,
			isaPkg::JMPZ2N_2,
			isaPkg::JMP_1,
			isaPkg::JMP_2,
			isaPkg::JMP_4: nextMemCtrl = ctrlPkg::MEM_IREAD;

			default: nextMemCtrl = ctrlPkg::MEM_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state     <= isaPkg::FETCH_1;
			aluOp     <= ctrlPkg::ALU_NONE;
			busSelect <= ctrlPkg::BS_AC;
			pCtrl     <= ctrlPkg::P_GSP;
			memCtrl   <= ctrlPkg::MEM_IDLE;
			rstEn     <= '0;
			incEn     <= '0;
			wrtEn     <= '0;
		end else begin
			state     <= curState;
			aluOp     <= nextAluOp;
			busSelect <= nextBusSelect;
			pCtrl     <= nextPCtrl;
			memCtrl   <= nextMemCtrl;
			rstEn     <= nextRstEn;
			incEn     <= nextIncEn;
			wrtEn     <= nextWrtEn;
		end
	end

endmodule

/* src/stateSequencer.sv */
`timescale 1ns/10ps

module stateSequencer (
	input  logic          clk,
	input  logic          rstN,
	input  logic          iacq,
	input  logic          acq,
	input  logic          z1,
	input  logic          z2,
	input  isaPkg::stateT entryState,
	output isaPkg::stateT curState
);

	isaPkg::stateT nextState;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			curState <= isaPkg::FETCH_1;
		end else begin
			curState <= nextState;
		end
	end

	always_comb begin
		nextState = isaPkg::FETCH_1;
		case (curState)
			// Instruction fetch
			isaPkg::FETCH_1: nextState = iacq ? isaPkg::FETCH_2 : isaPkg::FETCH_1;
			isaPkg::FETCH_2: nextState = isaPkg::FETCH_3;
			isaPkg::FETCH_3: nextState = entryState;

			// Single-cycle states
			isaPkg::RSTALL,
			isaPkg::RSTAC,
			isaPkg::RSTADDR,
			isaPkg::RSTGSP,
			isaPkg::RSTMC,
			isaPkg::RSTCP,
			isaPkg::RSTRP,
			isaPkg::INCGSP,
			isaPkg::INCAC,
			isaPkg::INCCP,
			isaPkg::INCRP,
			isaPkg::INCMC,
			isaPkg::INCSTP,
			isaPkg::ADD,
			isaPkg::MUL1,
			isaPkg::MUL2,
			isaPkg::DIV,
			isaPkg::MOD: nextState = isaPkg::FETCH_1;

			// Loads wait for the data memory
			isaPkg::LDADDR_1: nextState = acq ? isaPkg::LDADDR_2 : isaPkg::LDADDR_1;
			isaPkg::LDAC_1:   nextState = acq ? isaPkg::LDAC_2 : isaPkg::LDAC_1;
			isaPkg::LDMULR_1: nextState = acq ? isaPkg::LDMULR_2 : isaPkg::LDMULR_1;
			isaPkg::LDRP_1:   nextState = acq ? isaPkg::LDRP_2 : isaPkg::LDRP_1;
			isaPkg::LDCP_1:   nextState = acq ? isaPkg::LDCP_2 : isaPkg::LDCP_1;
			isaPkg::LDADDR_2,
			isaPkg::LDAC_2,
			isaPkg::LDMULR_2,
			isaPkg::LDRP_2,
			isaPkg::LDCP_2:   nextState = isaPkg::FETCH_1;

			isaPkg::STSP_1:   nextState = acq ? isaPkg::FETCH_1 : isaPkg::STSP_1;

			// Branch on zero flag 1, taken when set
			isaPkg::JMPZ1:    nextState = z1 ? isaPkg::JMPZ1Y_1 : isaPkg::JMPZ1N_1;
			isaPkg::JMPZ1Y_1: nextState = iacq ? isaPkg::JMPZ1Y_2 : isaPkg::JMPZ1Y_1;
			isaPkg::JMPZ1Y_2: nextState = isaPkg::JMPZ1Y_3;
			isaPkg::JMPZ1Y_3: nextState = isaPkg::FETCH_1;
			isaPkg::JMPZ1N_1: nextState = isaPkg::JMPZ1N_2;
			isaPkg::JMPZ1N_2: nextState = iacq ? isaPkg::JMPZ1N_3 : isaPkg::JMPZ1N_2;
			isaPkg::JMPZ1N_3: nextState = isaPkg::FETCH_1;

			// Branch on zero flag 2, taken when clear
			isaPkg::JMPZ2:    nextState = z2 ? isaPkg::JMPZ2N_1 : isaPkg::JMPZ2Y_1;
			isaPkg::JMPZ2Y_1: nextState = iacq ? isaPkg::JMPZ2Y_2 : isaPkg::JMPZ2Y_1;
			isaPkg::JMPZ2Y_2: nextState = isaPkg::JMPZ2Y_3;
			isaPkg::JMPZ2Y_3: nextState = isaPkg::FETCH_1;
			isaPkg::JMPZ2N_1: nextState = isaPkg::JMPZ2N_2;
			// Short chain, returns straight to fetch
			isaPkg::JMPZ2N_2: nextState = iacq ? isaPkg::FETCH_1 : isaPkg::JMPZ2N_2;

			// Unconditional jump
			isaPkg::JMP_1:    nextState = iacq ? isaPkg::JMP_2 : isaPkg::JMP_1;
			isaPkg::JMP_2:    nextState = isaPkg::JMP_3;
			isaPkg::JMP_3:    nextState = isaPkg::JMP_4;
			isaPkg::JMP_4:    nextState = isaPkg::FETCH_1;

			// Halt
			isaPkg::ENDOP:    nextState = isaPkg::ENDOP;

			default:          nextState = isaPkg::FETCH_1;
		endcase
	end

endmodule

/* src/insDecode.sv */
`timescale 1ns/10ps
`include "ctrlUnit_consts.svh"

module insDecode (
	input  logic [`STATE_WIDTH-1:0] ins,
	output isaPkg::stateT           entryState
);

	// Legal opcodes pass through as their own entry state
	always_comb begin
		case (ins)
			isaPkg::RSTALL,
			isaPkg::RSTAC,
			isaPkg::RSTADDR,
			isaPkg::RSTGSP,
			isaPkg::RSTMC,
			isaPkg::RSTCP,
			isaPkg::RSTRP,
			isaPkg::INCGSP,
			isaPkg::INCAC,
			isaPkg::INCCP,
			isaPkg::INCRP,
			isaPkg::INCMC,
			isaPkg::INCSTP,
			isaPkg::LDADDR_1,
			isaPkg::LDAC_1,
			isaPkg::LDMULR_1,
			isaPkg::LDRP_1,
			isaPkg::LDCP_1,
			isaPkg::STSP_1,
			isaPkg::ADD,
			isaPkg::MUL1,
			isaPkg::MUL2,
			isaPkg::DIV,
			isaPkg::MOD,
			isaPkg::JMPZ1,
			isaPkg::JMPZ2,
			isaPkg::JMP_1,
			isaPkg::ENDOP: begin
				entryState = isaPkg::stateT'(ins);
			end
			// Illegal byte, including internal state codes
			default: begin
				entryState = isaPkg::FETCH_1;
			end
		endcase
	end

endmodule

/* src/ctrlPkg.sv */
`include "ctrlUnit_consts.svh"

package ctrlPkg;

	typedef enum logic [`ALU_OP_WIDTH-1:0] {
		ALU_NONE = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_MUL  = 3'd2,
		ALU_DIV  = 3'd3,
		ALU_MOD  = 3'd4
	} aluOpT;

	// Bus sources seen by the datapath
	typedef enum logic [`BUS_SEL_WIDTH-1:0] {
		BS_AC     = 4'd0,
		BS_MEMOUT = 4'd1,
		BS_ADDR   = 4'd2,
		BS_MULR   = 4'd3,
		BS_MV     = 4'd4,
		BS_WV     = 4'd5,
		BS_RP     = 4'd6,
		BS_CP     = 4'd7
	} busSelT;

	// Data memory address pointer
	typedef enum logic [`P_CTRL_WIDTH-1:0] {
		P_GSP = 2'd0,
		P_RP  = 2'd1,
		P_CP  = 2'd2,
		P_STP = 2'd3
	} pCtrlT;

	typedef enum logic [`MEM_CTRL_WIDTH-1:0] {
		MEM_IDLE  = 4'd0,
		MEM_READ  = 4'd1,
		MEM_WRITE = 4'd2,
		MEM_IREAD = 4'd3
	} memCtrlT;

	// Bit positions in rstEn, incEn and wrtEn
	typedef enum int unsigned {
		R_PC   = 0,
		R_IR   = 1,
		R_GSP  = 2,
		R_RP   = 3,
		R_CP   = 4,
		R_STP  = 5,
		R_CID  = 6,
		R_EOPC = 7,
		R_MC   = 8,
		R_MV   = 9,
		R_WV   = 10,
		R_MULR = 11,
		R_ADDR = 12,
		R_AC   = 13
	} regIdxT;

endpackage

/* src/isaPkg.sv */
`include "ctrlUnit_consts.svh"

package isaPkg;

	// Opcodes double as entry states; internal states live from 8'hC0 up
	typedef enum logic [`STATE_WIDTH-1:0] {
		// Reset group
		RSTALL   = 8'h01,
		RSTAC    = 8'h02,
		RSTADDR  = 8'h03,
		RSTGSP   = 8'h04,
		RSTMC    = 8'h05,
		RSTCP    = 8'h06,
		RSTRP    = 8'h07,
		// Increment group
		INCGSP   = 8'h10,
		INCAC    = 8'h11,
		INCCP    = 8'h12,
		INCRP    = 8'h13,
		INCMC    = 8'h14,
		INCSTP   = 8'h15,
		// Loads and store, first step
		LDADDR_1 = 8'h20,
		LDAC_1   = 8'h21,
		LDMULR_1 = 8'h22,
		LDRP_1   = 8'h23,
		LDCP_1   = 8'h24,
		STSP_1   = 8'h28,
		// ALU
		ADD      = 8'h30,
		MUL1     = 8'h31,
		MUL2     = 8'h32,
		DIV      = 8'h33,
		MOD      = 8'h34,
		// Jumps
		JMPZ1    = 8'h40,
		JMPZ2    = 8'h41,
		JMP_1    = 8'h42,
		ENDOP    = 8'hFF,
		// Fetch
		FETCH_1  = 8'hC0,
		FETCH_2  = 8'hC1,
		FETCH_3  = 8'hC2,
		// Load second steps
		LDADDR_2 = 8'hC8,
		LDAC_2   = 8'hC9,
		LDMULR_2 = 8'hCA,
		LDRP_2   = 8'hCB,
		LDCP_2   = 8'hCC,
		// Conditional jump chains
		JMPZ1Y_1 = 8'hD0,
		JMPZ1Y_2 = 8'hD1,
		JMPZ1Y_3 = 8'hD2,
		JMPZ1N_1 = 8'hD4,
		JMPZ1N_2 = 8'hD5,
		JMPZ1N_3 = 8'hD6,
		JMPZ2Y_1 = 8'hD8,
		JMPZ2Y_2 = 8'hD9,
		JMPZ2Y_3 = 8'hDA,
		JMPZ2N_1 = 8'hDC,
		JMPZ2N_2 = 8'hDD,
		// Unconditional jump tail
		JMP_2    = 8'hE1,
		JMP_3    = 8'hE2,
		JMP_4    = 8'hE3
	} stateT;

endpackage

/* src/ctrlUnit_consts.svh */
`ifndef CTRL_UNIT_CONSTS_SVH
`define CTRL_UNIT_CONSTS_SVH

// Datapath registers driven by the one-hot enables
`define REG_COUNT 14

// State register and instruction byte
`define STATE_WIDTH 8

// Control field widths
`define ALU_OP_WIDTH 3
`define BUS_SEL_WIDTH 4
`define P_CTRL_WIDTH 2
`define MEM_CTRL_WIDTH 4

// Extra cycles allowed past the computed run length
`define TIMEOUT_SLACK 64

`endif
